// File: compile.f
common/rv_isa_pkg.sv
common/core_pkg.sv
core/fetch_stage.sv
core/decode_stage.sv
core/execute_stage.sv
core/result_stage.sv
src/mini_rv_core.sv
verif/mini_rv_core_checker.sv
verif/mini_rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mini_rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module mini_rv_core_tb \
  -o mini_rv_core_sim || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/mini_rv_core_sim 2>&1)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verif/mini_rv_core_tb.sv
`timescale 1ns/1ps

module mini_rv_core_tb;

  localparam int N_TESTS     = 6;
  localparam int MAX_PROG    = 16;
  localparam int MAX_OUT     = 4;
  localparam int WAIT_MAX    = 200;
  localparam int IDLE_CYCLES = 8;
  localparam int TAIL_CYCLES = 20;
  localparam rv_isa_pkg::word_t HALT = 32'h0000_006f; // jal x0, 0

  typedef struct {
    string             name;
    rv_isa_pkg::word_t prog [MAX_PROG];
    int                n_exp;
    rv_isa_pkg::word_t exp_words [MAX_OUT];
  } test_t;

  // x31 holds the output port base 0x8000_0000 in every program
  test_t tests [N_TESTS] = '{
    '{"alu_reg", '{32'h80000fb7, 32'h00500093, 32'hffd00113, 32'h402081b3,
                   32'h003fa023, 32'h00112233, 32'h004fa023, 32'h001092b3,
                   32'h00115333, 32'h005fa023, 32'h006fa023, HALT,
                   HALT, HALT, HALT, HALT},
      4, '{32'h0000_0008, 32'h0000_0001, 32'h0000_00a0, 32'h07ff_ffff}},
    '{"alu_imm", '{32'h80000fb7, 32'h123450b7, 32'h6780e113, 32'h002fa023,
                   32'h0f017193, 32'hfff1c213, 32'h00022293, 32'h003fa023,
                   32'h004fa023, 32'h005fa023, HALT, HALT,
                   HALT, HALT, HALT, HALT},
      4, '{32'h1234_5678, 32'h0000_0070, 32'hffff_ff8f, 32'h0000_0001}},
    // Chained ALU ops, then lw used by the very next sw and or
    '{"forward", '{32'h80000fb7, 32'h00700093, 32'h00108133, 32'h001141b3,
                   32'h00302023, 32'h00002203, 32'h004fa023, 32'h002262b3,
                   32'h005fa023, 32'h0022f333, 32'h006fa023, HALT,
                   HALT, HALT, HALT, HALT},
      3, '{32'h0000_0009, 32'h0000_000f, 32'h0000_000e, 32'h0}},
    // Port store at 0x8000_0008 must leave dmem word 2 alone
    '{"mem_io",  '{32'h80000fb7, 32'h12300093, 32'h00102423, 32'h45600113,
                   32'h00202623, 32'h00802183, 32'h00c02203, 32'h003fa023,
                   32'h004fa223, 32'h002fa423, 32'h00802283, 32'h005fa023,
                   HALT, HALT, HALT, HALT},
      4, '{32'h0000_0123, 32'h0000_0456, 32'h0000_0456, 32'h0000_0123}},
    '{"branch",  '{32'h80000fb7, 32'h00100093, 32'h00108663, 32'h001fa023,
                   32'h001fa023, 32'h00109463, 32'h00300113, 32'h00000193,
                   32'h00518193, 32'hfff10113, 32'hfe011ce3, 32'h003fa023,
                   32'h002fa023, HALT, HALT, HALT},
      2, '{32'h0000_000f, 32'h0000_0000, 32'h0, 32'h0}},
    '{"jal_x0",  '{32'h80000fb7, 32'h00c000ef, 32'h00100293, 32'h005fa023,
                   32'h001fa023, 32'h0080006f, 32'h001fa023, 32'h00700013,
                   32'h000fa023, 32'h001fa023, HALT, HALT,
                   HALT, HALT, HALT, HALT},
      3, '{32'h0000_0008, 32'h0000_0000, 32'h0000_0008, 32'h0}}
  };

  logic                 clk       = 1'b0;
  logic                 reset     = 1'b1;
  logic                 run       = 1'b0;
  logic                 prog_we   = 1'b0;
  core_pkg::imem_addr_t prog_addr = '0;
  rv_isa_pkg::word_t    prog_data = '0;
  logic                 io_valid;
  rv_isa_pkg::word_t    io_data;

  int errors = 0;
  int checks = 0;
  int failed = 0;

  mini_rv_core i_mini_rv_core (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .io_valid  (io_valid),
    .io_data   (io_data)
  );

  always #5 clk = ~clk; // 10 ns period

  task automatic check_word(input string what, input rv_isa_pkg::word_t got,
                            input rv_isa_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic reset_core();
    @(posedge clk);
    reset <= 1'b1;
    run   <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic load_program(input int idx);
    int i;
    for (i = 0; i < MAX_PROG; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= core_pkg::imem_addr_t'(i);
      prog_data <= tests[idx].prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  // Counts output pulses over a fixed window
  task automatic count_pulses(input int cycles, output int pulses);
    int i;
    pulses = 0;
    for (i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (io_valid) begin
        pulses++;
      end
    end
  endtask

  task automatic wait_io_word(output rv_isa_pkg::word_t word, output bit found);
    int waited;
    found  = 1'b0;
    word   = '0;
    waited = 0;
    while (!found && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
      if (io_valid) begin
        found = 1'b1;
        word  = io_data;
      end
    end
  endtask

  task automatic run_test(input int idx);
    rv_isa_pkg::word_t got [MAX_OUT];
    rv_isa_pkg::word_t word;
    int n_got;
    int pulses;
    int errors_before;
    int i;
    bit found;
    errors_before = errors;
    n_got = 0;
    found = 1'b1;
    reset_core();
    load_program(idx);
    count_pulses(IDLE_CYCLES, pulses); // Run still low
    check_count($sformatf("%s idle io pulses", tests[idx].name), pulses, 0);
    @(posedge clk);
    run <= 1'b1;
    while (found && n_got < tests[idx].n_exp) begin
      wait_io_word(word, found);
      if (found) begin
        got[n_got] = word;
        n_got++;
      end
    end
    if (!found) begin
      errors++;
      $display("Timeout in test %s: output word %0d did not arrive within %0d cycles",
               tests[idx].name, n_got, WAIT_MAX);
    end
    count_pulses(TAIL_CYCLES, pulses); // Program sits in its halt loop
    check_count($sformatf("%s output count", tests[idx].name), n_got + pulses,
                tests[idx].n_exp);
    for (i = 0; i < n_got; i++) begin
      check_word($sformatf("%s word %0d", tests[idx].name, i), got[i],
                 tests[idx].exp_words[i]);
    end
    @(posedge clk);
    run <= 1'b0;
    if (errors != errors_before) begin
      failed++;
    end
    $display("Test %s %s", tests[idx].name, (errors == errors_before) ? "passed" : "failed");
  endtask

  initial begin
    int t;
    for (t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
             N_TESTS, failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verif/mini_rv_core_checker.sv
`timescale 1ns/1ps

module mini_rv_core_checker (
  input logic               clk,
  input logic               reset,
  input logic               io_valid,
  input rv_isa_pkg::word_t  io_data,
  input logic               redirect,
  input core_pkg::dec_exe_t dec_exe
);

  // Output port comes out of reset quiet
  io_low_after_reset: assert property (@(posedge clk) reset |=> !io_valid)
    else $error("io_valid high in the cycle after reset");

  io_data_known: assert property (@(posedge clk) disable iff (reset)
    io_valid |-> !$isunknown(io_data))
    else $error("io_data has unknown bits while io_valid is high");

  // Slot behind a taken branch or jump gets squashed
  flush_after_redirect: assert property (@(posedge clk) disable iff (reset)
    redirect |=> !dec_exe.valid)
    else $error("Decode output still valid after a redirect");

endmodule

bind mini_rv_core mini_rv_core_checker i_mini_rv_core_checker (
  .clk      (clk),
  .reset    (reset),
  .io_valid (io_valid),
  .io_data  (io_data),
  .redirect (redirect),
  .dec_exe  (dec_exe)
);

// File: src/mini_rv_core.sv
`timescale 1ns/1ps

module mini_rv_core (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 run,
  input  logic                 prog_we,
  input  core_pkg::imem_addr_t prog_addr,
  input  rv_isa_pkg::word_t    prog_data,
  output logic                 io_valid,
  output rv_isa_pkg::word_t    io_data
);

  core_pkg::fetch_out_t fetch_out;
  rv_isa_pkg::word_t    instr;
  core_pkg::dec_exe_t   dec_exe;
  core_pkg::exe_res_t   exe_res;
  core_pkg::wb_t        wb;

  logic                 redirect;
  rv_isa_pkg::word_t    redirect_pc;
  rv_isa_pkg::word_t    dmem_addr;
  rv_isa_pkg::word_t    dmem_wdata;
  logic                 dmem_we;
  logic                 io_we;

  fetch_stage i_fetch_stage (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .fetch_out   (fetch_out),
    .instr       (instr)
  );

  decode_stage i_decode_stage (
    .clk       (clk),
    .reset     (reset),
    .fetch_out (fetch_out),
    .instr     (instr),
    .flush     (redirect),  // Drops the slot behind a taken branch
    .wb        (wb),
    .dec_out   (dec_exe)
  );

  execute_stage i_execute_stage (
    .clk         (clk),
    .reset       (reset),
    .dec_in      (dec_exe),
    .wb          (wb),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_we     (dmem_we),
    .io_we       (io_we),
    .res_out     (exe_res)
  );

  result_stage i_result_stage (
    .clk        (clk),
    .reset      (reset),
    .res_in     (exe_res),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .io_we      (io_we),
    .wb         (wb),
    .io_valid   (io_valid),
    .io_data    (io_data)
  );

endmodule

// File: core/result_stage.sv
`timescale 1ns/1ps

module result_stage (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::exe_res_t res_in,
  input  rv_isa_pkg::word_t  dmem_addr,
  input  rv_isa_pkg::word_t  dmem_wdata,
  input  logic               dmem_we,
  input  logic               io_we,
  output core_pkg::wb_t      wb,
  output logic               io_valid,
  output rv_isa_pkg::word_t  io_data
);

  rv_isa_pkg::word_t    dmem [core_pkg::DMEM_DEPTH];
  rv_isa_pkg::word_t    load_data;
  core_pkg::dmem_addr_t dmem_idx;

  assign dmem_idx = dmem_addr[$bits(core_pkg::dmem_addr_t)+1:2];

  // Read and write at the execute edge
  always_ff @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_idx] <= dmem_wdata;
    end
    load_data <= dmem[dmem_idx];
  end

  // Output port, one cycle pulse per store
  always_ff @(posedge clk) begin
    if (reset) begin
      io_valid <= 1'b0;
    end else begin
      io_valid <= io_we;
    end
    if (io_we) begin
      io_data <= dmem_wdata;
    end
  end

  // Write-back select
  assign wb.we    = res_in.valid && res_in.reg_we;
  assign wb.rd    = res_in.rd;
  assign wb.value = res_in.load ? load_data : res_in.result;

endmodule

// File: core/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::dec_exe_t dec_in,
  input  core_pkg::wb_t      wb,
  output logic               redirect,
  output rv_isa_pkg::word_t  redirect_pc,
  output rv_isa_pkg::word_t  dmem_addr,
  output rv_isa_pkg::word_t  dmem_wdata,
  output logic               dmem_we,
  output logic               io_we,
  output core_pkg::exe_res_t res_out
);

  rv_isa_pkg::word_t  rs1_val;
  rv_isa_pkg::word_t  rs2_val;
  rv_isa_pkg::word_t  op_b;
  rv_isa_pkg::word_t  alu_y;
  logic               io_sel;
  core_pkg::exe_res_t res_next;

  // wb holds the instruction one ahead and its load data
  function automatic rv_isa_pkg::word_t forward(
    input rv_isa_pkg::reg_addr_t idx,
    input rv_isa_pkg::word_t     decoded,
    input core_pkg::wb_t         wbk
  );
    rv_isa_pkg::word_t value;
    value = decoded;
    if (wbk.we && wbk.rd == idx && idx != '0) begin
      value = wbk.value;
    end
    return value;
  endfunction

  assign rs1_val = forward(dec_in.rs1, dec_in.rs1_val, wb);
  assign rs2_val = forward(dec_in.rs2, dec_in.rs2_val, wb);
  assign op_b    = dec_in.use_imm ? dec_in.imm : rs2_val;

  always_comb begin
    case (dec_in.alu_op)
      core_pkg::ALU_ADD:    alu_y = rs1_val + op_b;
      core_pkg::ALU_SUB:    alu_y = rs1_val - op_b;
      core_pkg::ALU_AND:    alu_y = rs1_val & op_b;
      core_pkg::ALU_OR:     alu_y = rs1_val | op_b;
      core_pkg::ALU_XOR:    alu_y = rs1_val ^ op_b;
      core_pkg::ALU_SLL:    alu_y = rs1_val << op_b[4:0];
      core_pkg::ALU_SRL:    alu_y = rs1_val >> op_b[4:0];
      core_pkg::ALU_SLT:    alu_y = {31'b0, $signed(rs1_val) < $signed(op_b)};
      core_pkg::ALU_PASS_B: alu_y = op_b;
      default:              alu_y = rs1_val + op_b;
    endcase
  end

  // Branch and jump resolution
  assign redirect = dec_in.valid && (dec_in.jump
                    || (dec_in.beq && rs1_val == rs2_val)
                    || (dec_in.bne && rs1_val != rs2_val));
  assign redirect_pc = dec_in.pc + dec_in.imm;

  // Store routing by the IO address bit
  assign io_sel     = alu_y[core_pkg::IO_ADDR_BIT];
  assign dmem_addr  = alu_y;
  assign dmem_wdata = rs2_val;
  assign dmem_we    = dec_in.valid && dec_in.store && !io_sel;
  assign io_we      = dec_in.valid && dec_in.store && io_sel;

  always_comb begin
    res_next.valid  = dec_in.valid;
    res_next.rd     = dec_in.rd;
    res_next.result = dec_in.jump ? dec_in.pc + core_pkg::PC_STEP : alu_y; // Link for JAL
    res_next.load   = dec_in.load;
    res_next.reg_we = dec_in.reg_we;
  end

  always_ff @(posedge clk) begin
    res_out <= res_next;
    if (reset) begin
      res_out.valid <= 1'b0;
    end
  end

endmodule

// File: core/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  core_pkg::fetch_out_t fetch_out,
  input  rv_isa_pkg::word_t    instr,
  input  logic                 flush,
  input  core_pkg::wb_t        wb,
  output core_pkg::dec_exe_t   dec_out
);

  rv_isa_pkg::word_t     regs [32];
  rv_isa_pkg::opcode_t   opcode;
  rv_isa_pkg::funct3_t   funct3;
  rv_isa_pkg::funct7_t   funct7;
  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rs2;
  rv_isa_pkg::word_t     imm_i;
  rv_isa_pkg::word_t     imm_s;
  rv_isa_pkg::word_t     imm_b;
  rv_isa_pkg::word_t     imm_u;
  rv_isa_pkg::word_t     imm_j;
  core_pkg::dec_exe_t    dec_next;
  logic                  supported;

  assign opcode = rv_isa_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Register file, x0 is never written
  always_ff @(posedge clk) begin
    if (wb.we && wb.rd != '0) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // Read with write-through from the result stage
  function automatic rv_isa_pkg::word_t read_reg(input rv_isa_pkg::reg_addr_t idx);
    rv_isa_pkg::word_t value;
    if (idx == '0) begin
      value = '0;
    end else if (wb.we && wb.rd == idx) begin
      value = wb.value;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  always_comb begin
    dec_next         = '0;
    supported        = 1'b1;
    dec_next.pc      = fetch_out.pc;
    dec_next.rs1     = rs1;
    dec_next.rs2     = rs2;
    dec_next.rs1_val = read_reg(rs1);
    dec_next.rs2_val = read_reg(rs2);
    dec_next.rd      = instr[11:7];
    dec_next.alu_op  = core_pkg::ALU_ADD;
    case (opcode)
      rv_isa_pkg::OP_IMM: begin
        dec_next.imm     = imm_i;
        dec_next.use_imm = 1'b1;
        dec_next.reg_we  = 1'b1;
        case (funct3)
          rv_isa_pkg::F3_ADD_SUB: dec_next.alu_op = core_pkg::ALU_ADD;
          rv_isa_pkg::F3_AND:     dec_next.alu_op = core_pkg::ALU_AND;
          rv_isa_pkg::F3_OR:      dec_next.alu_op = core_pkg::ALU_OR;
          rv_isa_pkg::F3_XOR:     dec_next.alu_op = core_pkg::ALU_XOR;
          rv_isa_pkg::F3_SLT:     dec_next.alu_op = core_pkg::ALU_SLT;
          default:                supported = 1'b0; // No immediate shifts
        endcase
      end
      rv_isa_pkg::OP: begin
        dec_next.reg_we = 1'b1;
        case ({funct7, funct3})
          {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB}: dec_next.alu_op = core_pkg::ALU_ADD;
          {rv_isa_pkg::F7_ALT,  rv_isa_pkg::F3_ADD_SUB}: dec_next.alu_op = core_pkg::ALU_SUB;
          {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND}:     dec_next.alu_op = core_pkg::ALU_AND;
          {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR}:      dec_next.alu_op = core_pkg::ALU_OR;
          {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR}:     dec_next.alu_op = core_pkg::ALU_XOR;
          {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLL}:     dec_next.alu_op = core_pkg::ALU_SLL;
          {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SRL}:     dec_next.alu_op = core_pkg::ALU_SRL;
          {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLT}:     dec_next.alu_op = core_pkg::ALU_SLT;
          default:                                       supported = 1'b0;
        endcase
      end
      rv_isa_pkg::LUI: begin
        dec_next.imm     = imm_u;
        dec_next.use_imm = 1'b1;
        dec_next.alu_op  = core_pkg::ALU_PASS_B;
        dec_next.reg_we  = 1'b1;
      end
      rv_isa_pkg::LOAD: begin
        dec_next.imm     = imm_i;
        dec_next.use_imm = 1'b1;
        dec_next.load    = 1'b1;
        dec_next.reg_we  = 1'b1;
        supported        = (funct3 == rv_isa_pkg::F3_LW);
      end
      rv_isa_pkg::STORE: begin
        dec_next.imm     = imm_s;
        dec_next.use_imm = 1'b1;
        dec_next.store   = 1'b1;
        supported        = (funct3 == rv_isa_pkg::F3_SW);
      end
      rv_isa_pkg::BRANCH: begin
        dec_next.imm = imm_b;
        dec_next.beq = (funct3 == rv_isa_pkg::F3_BEQ);
        dec_next.bne = (funct3 == rv_isa_pkg::F3_BNE);
        supported    = dec_next.beq || dec_next.bne;
      end
      rv_isa_pkg::JAL: begin
        dec_next.imm    = imm_j;
        dec_next.jump   = 1'b1;
        dec_next.reg_we = 1'b1; // Link value
      end
      default: supported = 1'b0;
    endcase
    dec_next.valid = fetch_out.valid && supported; // Unknown opcodes become bubbles
  end

  always_ff @(posedge clk) begin
    dec_out <= dec_next;
    if (reset || flush) begin
      dec_out.valid <= 1'b0;
    end
  end

endmodule

// File: core/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   run,
  input  logic                   redirect,
  input  rv_isa_pkg::word_t      redirect_pc,
  input  logic                   prog_we,
  input  core_pkg::imem_addr_t   prog_addr,
  input  rv_isa_pkg::word_t      prog_data,
  output core_pkg::fetch_out_t   fetch_out,
  output rv_isa_pkg::word_t      instr
);

  rv_isa_pkg::word_t    pc;
  core_pkg::imem_addr_t rd_idx;
  rv_isa_pkg::word_t    imem [core_pkg::IMEM_DEPTH];

  assign rd_idx = pc[$bits(core_pkg::imem_addr_t)+1:2]; // Word index

  // Instruction memory, program port on the write side
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
    instr <= imem[rd_idx]; // Arrives together with fetch_out
  end

  // PC and fetch slot valid
  always_ff @(posedge clk) begin
    if (reset) begin
      pc              <= core_pkg::RESET_PC;
      fetch_out.valid <= 1'b0;
    end else begin
      if (redirect) begin
        pc <= redirect_pc;  // Taken branch or jump in execute
      end else if (run) begin
        pc <= pc + core_pkg::PC_STEP;
      end
      // Word read this cycle is a wrong-path slot on redirect
      fetch_out.valid <= run && !redirect;
    end
    fetch_out.pc <= pc;
  end

endmodule

// File: common/core_pkg.sv
package core_pkg;

  // Memory sizes in words
  localparam int IMEM_DEPTH = 1024;
  localparam int DMEM_DEPTH = 1024;

  typedef logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_t;
  typedef logic [$clog2(DMEM_DEPTH)-1:0] dmem_addr_t;

  localparam rv_isa_pkg::word_t RESET_PC = 32'h0000_0000;
  localparam rv_isa_pkg::word_t PC_STEP  = 32'd4; // One instruction

  // Stores with this address bit set go to the output port
  localparam int IO_ADDR_BIT = 31;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT,
    ALU_PASS_B  // LUI
  } alu_op_t;

  typedef struct packed {
    logic              valid;
    rv_isa_pkg::word_t pc;
  } fetch_out_t;

  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::word_t     pc;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_isa_pkg::word_t     rs1_val;
    rv_isa_pkg::word_t     rs2_val;
    rv_isa_pkg::word_t     imm;
    rv_isa_pkg::reg_addr_t rd;
    alu_op_t               alu_op;
    logic                  use_imm; // Operand B from immediate
    logic                  load;
    logic                  store;
    logic                  beq;
    logic                  bne;
    logic                  jump;
    logic                  reg_we;
  } dec_exe_t;

  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     result; // ALU or link value
    logic                  load;
    logic                  reg_we;
  } exe_res_t;

  typedef struct packed {
    logic                  we;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     value;
  } wb_t;

endpackage

// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

  // Basic word and field types
  typedef logic [31:0] word_t;     // Data, address or instruction
  typedef logic [4:0]  reg_addr_t; // Register index
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_t;

  // funct3 for OP and OP_IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL     = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // funct3 for branches
  localparam funct3_t F3_BEQ = 3'b000;
  localparam funct3_t F3_BNE = 3'b001;

  // funct3 for word loads and stores
  localparam funct3_t F3_LW = 3'b010;
  localparam funct3_t F3_SW = 3'b010;

  // funct7 variants of register-register ops
  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000; // SUB

endpackage
